//--- common/elink_config.svh
// Downstream e-link configuration: channel count, FIFO sizing and word width
`ifndef ELINK_CONFIG_SVH
`define ELINK_CONFIG_SVH

// Number of e-link channels
`define ELINK_NUM_CHAN 4

// Words per channel FIFO
`define ELINK_FIFO_DEPTH 16

// Fill level that stalls the generator
`define ELINK_PFULL_LEVEL 12

// Fill level of the almost_full flag, one short of full
`define ELINK_AFULL_LEVEL 15

// Delimiter plus one byte
`define ELINK_WORD_W 10

`endif

//--- common/elink_pkg.sv
// E-link delimiter codes and the two decodings of a 10-bit e-link word
package elink_pkg;

  // Delimiter in the top two bits of every word
  typedef enum logic [1:0] {
    DLM_DATA = 2'd0,
    DLM_SOP  = 2'd1,
    DLM_EOP  = 2'd2,
    DLM_HDR  = 2'd3
  } delim_e;

  // One e-link word, read as payload or as a merger header
  typedef union packed {
    // Payload byte of a packet
    struct packed {
      delim_e     delim;
      logic [7:0] data;
    } data_view;

    // Header put in front of each packet by the merger
    struct packed {
      delim_e     delim;
      logic [2:0] chan;
      logic [4:0] seq;
    } header_view;
  } elink_word_u;

endpackage

//--- fifo_downstream/fifo_downstream.sv
// Synchronous downstream FIFO for 10-bit e-link words with registered fill flags
`timescale 1ns/1ps
`include "elink_config.svh"

module fifo_downstream
  import elink_pkg::*;
#(
  parameter int DEPTH = `ELINK_FIFO_DEPTH,
  parameter int PFULL = `ELINK_PFULL_LEVEL
)
(
  input  logic        clk_usr,
  input  logic        rst_n,
  input  elink_word_u din,
  input  logic        wr_en,
  input  logic        rd_en,
  output elink_word_u dout,
  output logic        full,
  output logic        empty,
  output logic        almost_full,
  output logic        prog_full
);

  localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  // Same distance from full as the default configuration
  localparam int AFULL = DEPTH - (`ELINK_FIFO_DEPTH - `ELINK_AFULL_LEVEL);

  logic [`ELINK_WORD_W-1:0] mem [DEPTH];
  logic [AW-1:0]            wr_ptr;
  logic [AW-1:0]            rd_ptr;
  logic [CNT_W-1:0]         count;
  logic [CNT_W-1:0]         count_next;
  logic                     do_wr;
  logic                     do_rd;

  // Pointer wrap for any depth
  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
    return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  always_comb
  begin
    count_next = count;
    if (do_wr && !do_rd)
      count_next = count + 1'b1;
    else if (do_rd && !do_wr)
      count_next = count - 1'b1;
  end

  always_ff @(posedge clk_usr)
  begin
    if (!rst_n)
    begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      full        <= 1'b0;
      empty       <= 1'b1;
      almost_full <= 1'b0;
      prog_full   <= 1'b0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= ptr_inc(wr_ptr);
      if (do_rd)
        rd_ptr <= ptr_inc(rd_ptr);
      count       <= count_next;
      // Flags track the count they are registered with
      full        <= (count_next == CNT_W'(DEPTH));
      empty       <= (count_next == '0);
      almost_full <= (count_next >= CNT_W'(AFULL));
      prog_full   <= (count_next >= CNT_W'(PFULL));
    end
  end

  // Storage and read port
  always_ff @(posedge clk_usr)
  begin
    if (do_wr)
      mem[wr_ptr] <= din;
    if (do_rd)
      dout <= mem[rd_ptr];
  end

endmodule

//--- rtl/frame_generator.sv
// Frame generator producing counting-byte packets round-robin over the channel FIFOs
`timescale 1ns/1ps
`include "elink_config.svh"

module frame_generator
  import elink_pkg::*;
#(
  parameter int NUM_CHAN = `ELINK_NUM_CHAN
)
(
  input  logic                clk_usr,
  input  logic                rst_n,
  input  logic                enable,
  input  logic                loop_en,
  input  logic [3:0]          pkt_len,
  input  logic [NUM_CHAN-1:0] prog_full,
  output elink_word_u         fifo_din,
  output logic [NUM_CHAN-1:0] wr_en,
  output logic                done
);

  localparam int CW = (NUM_CHAN > 1) ? $clog2(NUM_CHAN) : 1;

  // FSM encoding
  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_RUN  = 2'd1;
  localparam logic [1:0] ST_DONE = 2'd2;

  logic [1:0]    state;
  logic [CW-1:0] chan;
  logic [3:0]    pos;
  logic [7:0]    byte_cnt [NUM_CHAN];
  logic          finishing;
  logic          can_write;
  logic          last_byte;
  logic          last_chan;
  delim_e        delim;

  // Paused by a low enable or by the target FIFO filling up
  assign can_write = (state == ST_RUN) && enable && !prog_full[chan];
  assign last_byte = (pos == pkt_len);
  assign last_chan = (chan == CW'(NUM_CHAN - 1));

  // Delimiter from position in packet; a single-byte packet is EOP only
  always_comb
  begin
    if (last_byte)
      delim = DLM_EOP;
    else if (pos == 4'd0)
      delim = DLM_SOP;
    else
      delim = DLM_DATA;
  end

  always_ff @(posedge clk_usr)
  begin
    if (!rst_n)
    begin
      state     <= ST_IDLE;
      chan      <= '0;
      pos       <= '0;
      wr_en     <= '0;
      done      <= 1'b0;
      finishing <= 1'b0;
      for (int c = 0; c < NUM_CHAN; c++)
      begin
        byte_cnt[c] <= 8'(64 * c);
      end
    end
    else
    begin
      wr_en     <= '0;
      done      <= finishing;
      finishing <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          if (enable)
            state <= ST_RUN;
        end
        ST_RUN:
        begin
          if (can_write)
          begin
            wr_en[chan]    <= 1'b1;
            byte_cnt[chan] <= byte_cnt[chan] + 8'd1;
            if (last_byte)
            begin
              pos  <= '0;
              chan <= last_chan ? '0 : chan + 1'b1;
              // End of pass
              if (last_chan && !loop_en)
              begin
                state     <= ST_DONE;
                finishing <= 1'b1;
              end
            end
            else
            begin
              pos <= pos + 4'd1;
            end
          end
        end
        ST_DONE:
        begin
          // Rearm only after enable drops
          if (!enable)
            state <= ST_IDLE;
        end
        default:
        begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Word register shared by all FIFOs, qualified by wr_en
  always_ff @(posedge clk_usr)
  begin
    if (can_write)
    begin
      fifo_din.data_view.delim <= delim;
      fifo_din.data_view.data  <= byte_cnt[chan];
    end
  end

endmodule

//--- rtl/elink_merger.sv
// E-link merger draining channel FIFOs one packet at a time behind a header word
`timescale 1ns/1ps
`include "elink_config.svh"

module elink_merger
  import elink_pkg::*;
#(
  parameter int NUM_CHAN = `ELINK_NUM_CHAN
)
(
  input  logic                         clk_usr,
  input  logic                         rst_n,
  input  logic        [NUM_CHAN-1:0]   empty,
  input  elink_word_u [NUM_CHAN-1:0]   fifo_dout,
  input  logic                         out_en,
  output logic        [NUM_CHAN-1:0]   rd_en,
  output elink_word_u                  dout,
  output logic                         dout_valid
);

  localparam int CW = (NUM_CHAN > 1) ? $clog2(NUM_CHAN) : 1;

  localparam logic ST_PICK = 1'b0;
  localparam logic ST_DATA = 1'b1;

  logic          state;
  logic [CW-1:0] rr;
  logic [CW-1:0] cur;
  logic [CW-1:0] pick;
  logic [CW-1:0] idx;
  logic          found;
  logic [4:0]    seq [NUM_CHAN];
  // Read issued last cycle, word waiting on fifo_dout[cur]
  logic          pend;
  // Output slot holds a word not yet sent
  logic          hold;
  elink_word_u   out_word;
  logic          eop_now;
  logic          capture;
  logic          hdr_load;
  logic          rd_issue;

  // First non-empty channel at or after the round-robin pointer
  always_comb
  begin
    found = 1'b0;
    pick  = rr;
    idx   = rr;
    for (int i = NUM_CHAN - 1; i >= 0; i--)
    begin
      idx = CW'((int'(rr) + i) % NUM_CHAN);
      if (!empty[idx])
      begin
        found = 1'b1;
        pick  = idx;
      end
    end
  end

  assign eop_now  = pend && (fifo_dout[cur].data_view.delim == DLM_EOP);
  assign capture  = pend && (!hold || out_en);
  assign hdr_load = (state == ST_PICK) && found && out_en;

  // With out_en high a pending word is always captured, so a new read never
  // overruns it; nothing is fetched past the EOP
  assign rd_issue = (state == ST_DATA) && out_en && !empty[cur] && !eop_now;
  assign rd_en    = rd_issue ? (NUM_CHAN'(1) << cur) : '0;

  assign dout       = out_word;
  assign dout_valid = hold && out_en;

  always_ff @(posedge clk_usr)
  begin
    if (!rst_n)
    begin
      state <= ST_PICK;
      rr    <= '0;
      cur   <= '0;
      pend  <= 1'b0;
      hold  <= 1'b0;
      for (int c = 0; c < NUM_CHAN; c++)
      begin
        seq[c] <= '0;
      end
    end
    else
    begin
      if (hdr_load || capture)
        hold <= 1'b1;
      else if (dout_valid)
        hold <= 1'b0;

      if (rd_issue)
        pend <= 1'b1;
      else if (capture)
        pend <= 1'b0;

      if (hdr_load)
      begin
        cur   <= pick;
        state <= ST_DATA;
      end

      // Packet closed, move on to the next channel
      if (capture && eop_now)
      begin
        seq[cur] <= seq[cur] + 5'd1;
        rr       <= (cur == CW'(NUM_CHAN - 1)) ? '0 : cur + 1'b1;
        state    <= ST_PICK;
      end
    end
  end

  // Output word register
  always_ff @(posedge clk_usr)
  begin
    if (hdr_load)
    begin
      out_word.header_view.delim <= DLM_HDR;
      out_word.header_view.chan  <= 3'(pick);
      out_word.header_view.seq   <= seq[pick];
    end
    else if (capture)
    begin
      out_word <= fifo_dout[cur];
    end
  end

endmodule

//--- rtl/downstream_top.sv
// Downstream e-link path top: generator, per-channel FIFOs and packet merger
`timescale 1ns/1ps
`include "elink_config.svh"

module downstream_top
  import elink_pkg::*;
#(
  parameter int NUM_CHAN = `ELINK_NUM_CHAN
)
(
  input  logic        clk_usr,
  input  logic        rst_n,
  input  logic        enable,
  input  logic        loop_en,
  input  logic [3:0]  pkt_len,
  input  logic        out_en,
  output elink_word_u dout,
  output logic        dout_valid,
  output logic        done
);

  elink_word_u                gen_din;
  logic        [NUM_CHAN-1:0] gen_wr_en;
  logic        [NUM_CHAN-1:0] fifo_pfull;
  logic        [NUM_CHAN-1:0] fifo_full;
  logic        [NUM_CHAN-1:0] fifo_empty;
  elink_word_u [NUM_CHAN-1:0] fifo_dout;
  logic        [NUM_CHAN-1:0] mrg_rd_en;

  frame_generator #(
    .NUM_CHAN (NUM_CHAN)
  ) u_gen (
    .clk_usr   (clk_usr),
    .rst_n     (rst_n),
    .enable    (enable),
    .loop_en   (loop_en),
    .pkt_len   (pkt_len),
    .prog_full (fifo_pfull),
    .fifo_din  (gen_din),
    .wr_en     (gen_wr_en),
    .done      (done)
  );

  // One FIFO per channel, all fed from the shared generator word
  for (genvar i = 0; i < NUM_CHAN; i++)
  begin : g_fifo
    fifo_downstream #(
      .DEPTH (`ELINK_FIFO_DEPTH),
      .PFULL (`ELINK_PFULL_LEVEL)
    ) u_fifo (
      .clk_usr     (clk_usr),
      .rst_n       (rst_n),
      .din         (gen_din),
      .wr_en       (gen_wr_en[i]),
      .rd_en       (mrg_rd_en[i]),
      .dout        (fifo_dout[i]),
      .full        (fifo_full[i]),
      .empty       (fifo_empty[i]),
      .almost_full (),
      .prog_full   (fifo_pfull[i])
    );
  end

  elink_merger #(
    .NUM_CHAN (NUM_CHAN)
  ) u_merger (
    .clk_usr    (clk_usr),
    .rst_n      (rst_n),
    .empty      (fifo_empty),
    .fifo_dout  (fifo_dout),
    .out_en     (out_en),
    .rd_en      (mrg_rd_en),
    .dout       (dout),
    .dout_valid (dout_valid)
  );

endmodule

//--- bench/downstream_props.sv
// Protocol assertions for the downstream e-link top level, attached by bind
`timescale 1ns/1ps
`include "elink_config.svh"

module downstream_props #(
  parameter int NUM_CHAN = `ELINK_NUM_CHAN
)
(
  input logic                clk_usr,
  input logic                rst_n,
  input logic                out_en,
  input logic                dout_valid,
  input logic                done,
  input logic [NUM_CHAN-1:0] wr_en,
  input logic [NUM_CHAN-1:0] full,
  input logic [NUM_CHAN-1:0] rd_en
);

  // Violations seen so far, read by the testbench at the end
  int fail_cnt = 0;

  valid_needs_out_en: assert property (@(posedge clk_usr) disable iff (!rst_n)
    dout_valid |-> out_en)
  else
  begin
    $error("dout_valid raised while out_en is low");
    fail_cnt++;
  end

  no_write_when_full: assert property (@(posedge clk_usr) disable iff (!rst_n)
    (wr_en & full) == '0)
  else
  begin
    $error("FIFO written while full");
    fail_cnt++;
  end

  single_read: assert property (@(posedge clk_usr) disable iff (!rst_n)
    $onehot0(rd_en))
  else
  begin
    $error("more than one rd_en bit set");
    fail_cnt++;
  end

  done_one_cycle: assert property (@(posedge clk_usr) disable iff (!rst_n)
    done |=> !done)
  else
  begin
    $error("done held longer than one cycle");
    fail_cnt++;
  end

endmodule

bind downstream_top downstream_props #(
  .NUM_CHAN (NUM_CHAN)
) u_props (
  .clk_usr    (clk_usr),
  .rst_n      (rst_n),
  .out_en     (out_en),
  .dout_valid (dout_valid),
  .done       (done),
  .wr_en      (gen_wr_en),
  .full       (fifo_full),
  .rd_en      (mrg_rd_en)
);

//--- bench/tb_downstream.sv
// Testbench for the downstream e-link path with a packet reference model
`timescale 1ns/1ps
`include "elink_config.svh"

module tb_downstream;
  import elink_pkg::*;

  localparam int NUM_CHAN = `ELINK_NUM_CHAN;
  localparam int PASSES_A = 3;
  localparam int PASSES_B = 4;
  localparam int PASSES_C = 2;
  localparam int PASSES_D = 3;
  localparam int TOTAL_PKTS = (PASSES_A + PASSES_B + PASSES_C + PASSES_D) * NUM_CHAN;
  // 17 words per packet at worst, 4 cycles each
  localparam int WATCHDOG_CYCLES = TOTAL_PKTS * 17 * 4 + 1000;

  logic        clk_usr = 1'b0;
  logic        rst_n;
  logic        enable;
  logic        loop_en;
  logic [3:0]  pkt_len;
  logic        out_en = 1'b0;
  elink_word_u dout;
  logic        dout_valid;
  logic        done;

  bit          rand_mode = 1'b0;
  logic [31:0] rng_state = 32'd73;
  int          cur_len = 0;
  int          hdr_cnt = 0;
  int          eop_cnt = 0;
  int          word_cnt = 0;
  int          done_cnt = 0;
  int          pass_cnt = 0;

  // Reference model state
  logic [7:0]  exp_cnt [NUM_CHAN];
  logic [4:0]  exp_seq [NUM_CHAN];
  logic        in_packet;
  int          cur_ch;
  int          ch;
  int          pos;
  elink_word_u exp_word;

  downstream_top dut (
    .clk_usr    (clk_usr),
    .rst_n      (rst_n),
    .enable     (enable),
    .loop_en    (loop_en),
    .pkt_len    (pkt_len),
    .out_en     (out_en),
    .dout       (dout),
    .dout_valid (dout_valid),
    .done       (done)
  );

  always #5 clk_usr = ~clk_usr;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Expected payload word from the byte counter and the position in the packet
  function automatic elink_word_u expected_data(input logic [7:0] cnt, input int p,
                                                input int len);
    elink_word_u w;
    w.data_view.data = cnt;
    if (p == len)
      w.data_view.delim = DLM_EOP;
    else if (p == 0)
      w.data_view.delim = DLM_SOP;
    else
      w.data_view.delim = DLM_DATA;
    return w;
  endfunction

  task automatic abort_with_message(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    assert (got == exp)
    else
      abort_with_message($sformatf("** Error: %s expected 0x%h got 0x%h", name, exp, got));
  endtask

  // Consumer stall pattern
  always @(posedge clk_usr)
  begin
    if (rand_mode)
    begin
      rng_state = xorshift32(rng_state);
      out_en <= rng_state[4];
    end
    else
      out_en <= 1'b1;
  end

  always @(posedge clk_usr)
  begin
    if (rst_n && done)
      done_cnt <= done_cnt + 1;
    // EOP written to the last channel closes a generator pass
    if (rst_n && dut.gen_wr_en[NUM_CHAN-1] && dut.gen_din.data_view.delim == DLM_EOP)
      pass_cnt <= pass_cnt + 1;
  end

  // Output comparison against the reference model
  always @(posedge clk_usr)
  begin
    if (!rst_n)
    begin
      in_packet = 1'b0;
      cur_ch    = 0;
      pos       = 0;
      for (int c = 0; c < NUM_CHAN; c++)
      begin
        exp_cnt[c] = 8'(64 * c);
        exp_seq[c] = '0;
      end
    end
    else if (dout_valid)
    begin
      if (!in_packet)
      begin
        check_value("dout.header_view.delim", DLM_HDR, dout.header_view.delim);
        ch = dout.header_view.chan;
        assert (ch < NUM_CHAN)
        else
          abort_with_message("Header names a channel that does not exist");
        check_value("dout.header_view.seq", exp_seq[ch], dout.header_view.seq);
        cur_ch    = ch;
        pos       = 0;
        in_packet = 1'b1;
        hdr_cnt <= hdr_cnt + 1;
      end
      else
      begin
        exp_word = expected_data(exp_cnt[cur_ch], pos, cur_len);
        check_value("dout", exp_word, dout);
        exp_cnt[cur_ch] = exp_cnt[cur_ch] + 8'd1;
        pos = pos + 1;
        if (exp_word.data_view.delim == DLM_EOP)
        begin
          in_packet       = 1'b0;
          exp_seq[cur_ch] = exp_seq[cur_ch] + 5'd1;
          eop_cnt <= eop_cnt + 1;
        end
      end
      word_cnt <= word_cnt + 1;
    end
  end

  // One enable window of a given number of passes, then drain and idle
  task automatic run_passes(input logic [3:0] len, input int passes, input bit rnd);
    int pass_start;
    int hdr_start;
    int eop_start;
    int done_start;
    int word_start;
    pass_start = pass_cnt;
    hdr_start  = hdr_cnt;
    eop_start  = eop_cnt;
    done_start = done_cnt;
    word_start = word_cnt;
    @(posedge clk_usr);
    cur_len   <= len;
    pkt_len   <= len;
    loop_en   <= (passes > 1);
    rand_mode <= rnd;
    enable    <= 1'b1;
    // Drop loop_en once the next to last pass is written
    while (pass_cnt < pass_start + passes - 1)
      @(posedge clk_usr);
    loop_en <= 1'b0;
    while (done_cnt == done_start)
      @(posedge clk_usr);
    enable <= 1'b0;
    // Every packet of the window closed by its EOP
    while (eop_cnt - eop_start < passes * NUM_CHAN)
      @(posedge clk_usr);
    rand_mode <= 1'b0;
    repeat (40) @(posedge clk_usr);
    check_value("done pulses", 1, done_cnt - done_start);
    check_value("passes", passes, pass_cnt - pass_start);
    check_value("headers", passes * NUM_CHAN, hdr_cnt - hdr_start);
    check_value("words", passes * NUM_CHAN * (len + 2), word_cnt - word_start);
  endtask

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_usr);
    abort_with_message("Timeout: the output stream did not complete in time");
  end

  initial
  begin
    rst_n   = 1'b0;
    enable  = 1'b0;
    loop_en = 1'b0;
    pkt_len = 4'd0;
    repeat (4) @(posedge clk_usr);
    rst_n <= 1'b1;
    // Quiet while enable is low
    repeat (20)
    begin
      @(posedge clk_usr);
      check_value("dout_valid", 0, dout_valid);
      check_value("done", 0, done);
    end
    run_passes(4'd5, PASSES_A, 1'b0);
    run_passes(4'd5, PASSES_B, 1'b1);
    run_passes(4'd0, PASSES_C, 1'b1);
    run_passes(4'd15, PASSES_D, 1'b1);
    if (dut.u_props.fail_cnt == 0)
    begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
    else
      abort_with_message("Bound protocol assertions reported violations");
  end

endmodule

//--- build.f
+incdir+common
common/elink_pkg.sv
fifo_downstream/fifo_downstream.sv
rtl/frame_generator.sv
rtl/elink_merger.sv
rtl/downstream_top.sv
bench/downstream_props.sv
bench/tb_downstream.sv
